//--- hdl/cache_pkg.sv
`default_nettype none

package cache_pkg;

    localparam int ADDR_WIDTH = 16;
    localparam int WORD_BYTES = 4;
    localparam int LINE_BYTES = 16;
    localparam int WORD_WIDTH = WORD_BYTES * 8;
    localparam int LINE_WIDTH = LINE_BYTES * 8;
    localparam int WORD_OFFSET_WIDTH = $clog2(WORD_BYTES);
    localparam int LINE_OFFSET_WIDTH = $clog2(LINE_BYTES);
    localparam int LINE_ADDR_WIDTH = ADDR_WIDTH - LINE_OFFSET_WIDTH;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [WORD_WIDTH-1:0] word_t;
    typedef logic [LINE_WIDTH-1:0] line_t;

    typedef enum logic [1:0] {BYTE, HALF, WORD} access_mode_e;
    typedef enum logic [1:0] {INVALID, VALID, REQUESTED} line_state_e;

    // Byte lanes touched by an access inside its word
    function automatic logic [WORD_BYTES-1:0] mode_mask(
        access_mode_e mode,
        logic [WORD_OFFSET_WIDTH-1:0] offset
    );
        logic [WORD_BYTES-1:0] mask;
        case (mode)
            BYTE: mask = WORD_BYTES'(1) << offset;
            HALF: mask = WORD_BYTES'(3) << {offset[WORD_OFFSET_WIDTH-1:1], 1'b0};
            default: mask = '1;
        endcase
        return mask;
    endfunction

endpackage

`default_nettype wire

//--- hdl/store_buffer.sv
`default_nettype none

module store_buffer #(
    parameter int SB_DEPTH = 4,
    parameter int NUM_LINES = 8
) (
    input wire clock,
    input wire reset,
    input wire push,
    input wire cache_pkg::access_mode_e push_mode,
    input wire cache_pkg::addr_t push_addr,
    input wire cache_pkg::word_t push_data,
    input wire pop,
    input wire cache_pkg::addr_t lookup_addr,
    output cache_pkg::addr_t pop_addr,
    output cache_pkg::word_t pop_data,
    output logic [cache_pkg::WORD_BYTES-1:0] pop_mask,
    output cache_pkg::word_t fwd_data,
    output logic [cache_pkg::WORD_BYTES-1:0] fwd_mask,
    output logic [NUM_LINES-1:0] line_pending,
    output logic empty,
    output logic full
);

    localparam int PTR_WIDTH = (SB_DEPTH > 1) ? $clog2(SB_DEPTH) : 1;
    localparam int COUNT_WIDTH = $clog2(SB_DEPTH + 1);
    localparam int INDEX_WIDTH = $clog2(NUM_LINES);
    localparam int WORD_OFFSET_WIDTH = cache_pkg::WORD_OFFSET_WIDTH;

    cache_pkg::addr_t entry_addr [SB_DEPTH];
    cache_pkg::word_t entry_data [SB_DEPTH];
    logic [cache_pkg::WORD_BYTES-1:0] entry_mask [SB_DEPTH];

    logic [PTR_WIDTH-1:0] head;
    logic [PTR_WIDTH-1:0] tail;
    logic [COUNT_WIDTH-1:0] count;

    logic [WORD_OFFSET_WIDTH-1:0] push_offset;
    logic [WORD_OFFSET_WIDTH-1:0] lane_base;
    cache_pkg::word_t push_lanes;
    cache_pkg::addr_t push_word_addr;
    cache_pkg::addr_t lookup_word_addr;

    function automatic logic [PTR_WIDTH-1:0] next_ptr(logic [PTR_WIDTH-1:0] ptr);
        return (ptr == PTR_WIDTH'(SB_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign push_offset = push_addr[WORD_OFFSET_WIDTH-1:0];
    assign push_word_addr = {push_addr[cache_pkg::ADDR_WIDTH-1:WORD_OFFSET_WIDTH],
                             WORD_OFFSET_WIDTH'(0)};
    assign lookup_word_addr = {lookup_addr[cache_pkg::ADDR_WIDTH-1:WORD_OFFSET_WIDTH],
                               WORD_OFFSET_WIDTH'(0)};

    // Requester data sits in the low bits, move it to its lanes
    always_comb begin
        case (push_mode)
            cache_pkg::BYTE: lane_base = push_offset;
            cache_pkg::HALF: lane_base = {push_offset[WORD_OFFSET_WIDTH-1:1], 1'b0};
            default: lane_base = '0;
        endcase
    end

    assign push_lanes = push_data << {lane_base, 3'b000};

    assign empty = count == '0;
    assign full = count == COUNT_WIDTH'(SB_DEPTH);

    assign pop_addr = entry_addr[head];
    assign pop_data = entry_data[head];
    assign pop_mask = entry_mask[head];

    // Oldest first, so later stores overwrite earlier bytes
    always_comb begin
        int slot;
        fwd_data = '0;
        fwd_mask = '0;
        line_pending = '0;
        for (int i = 0; i < SB_DEPTH; i++) begin
            slot = (int'(head) + i) % SB_DEPTH;
            if (i < int'(count)) begin
                line_pending[entry_addr[slot][cache_pkg::LINE_OFFSET_WIDTH +: INDEX_WIDTH]] = 1'b1;
                if (entry_addr[slot] == lookup_word_addr) begin
                    for (int b = 0; b < cache_pkg::WORD_BYTES; b++) begin
                        if (entry_mask[slot][b]) begin
                            fwd_data[8*b +: 8] = entry_data[slot][8*b +: 8];
                            fwd_mask[b] = 1'b1;
                        end
                    end
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head <= '0;
            tail <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tail <= next_ptr(tail);
            end
            if (pop) begin
                head <= next_ptr(head);
            end
            count <= count + COUNT_WIDTH'(push) - COUNT_WIDTH'(pop);
        end
    end

    always_ff @(posedge clock) begin
        if (push) begin
            entry_addr[tail] <= push_word_addr;
            entry_data[tail] <= push_lanes;
            entry_mask[tail] <= cache_pkg::mode_mask(push_mode, push_offset);
        end
    end

    push_needs_room: assert property (
        @(posedge clock) disable iff (reset) push && full |-> pop
    );

    pop_needs_entry: assert property (
        @(posedge clock) disable iff (reset) pop |-> !empty
    );

endmodule

`default_nettype wire

//--- hdl/data_cache.sv
`default_nettype none

module data_cache #(
    parameter int NUM_LINES = 8,
    parameter int SB_DEPTH = 4
) (
    input wire clock,
    input wire reset,
    input wire req_read,
    input wire req_write,
    input wire cache_pkg::access_mode_e req_mode,
    input wire cache_pkg::addr_t req_addr,
    input wire cache_pkg::word_t req_data,
    input wire mem_busy,
    input wire fill_valid,
    input wire [cache_pkg::LINE_ADDR_WIDTH-1:0] fill_line_addr,
    input wire cache_pkg::line_t fill_data,
    output logic resp_hit,
    output cache_pkg::word_t resp_data,
    output logic mem_read,
    output logic mem_write,
    output logic [cache_pkg::LINE_ADDR_WIDTH-1:0] mem_line_addr,
    output cache_pkg::line_t mem_wdata
);

    localparam int WB = cache_pkg::WORD_BYTES;
    localparam int WORD_OFFSET_WIDTH = cache_pkg::WORD_OFFSET_WIDTH;
    localparam int LINE_OFFSET_WIDTH = cache_pkg::LINE_OFFSET_WIDTH;
    localparam int INDEX_WIDTH = $clog2(NUM_LINES);
    localparam int TAG_WIDTH = cache_pkg::LINE_ADDR_WIDTH - INDEX_WIDTH;
    localparam int WORD_SEL_WIDTH = LINE_OFFSET_WIDTH - WORD_OFFSET_WIDTH;

    cache_pkg::line_state_e line_state [NUM_LINES];
    logic [TAG_WIDTH-1:0] line_tag [NUM_LINES];
    cache_pkg::line_t line_data [NUM_LINES];
    logic [cache_pkg::LINE_BYTES-1:0] line_dirty [NUM_LINES];

    logic [INDEX_WIDTH-1:0] req_index;
    logic [TAG_WIDTH-1:0] req_tag;
    logic [WORD_SEL_WIDTH-1:0] req_word;
    logic [WORD_OFFSET_WIDTH-1:0] req_offset;

    cache_pkg::line_state_e cur_state;
    logic tag_match;
    logic cur_dirty;

    assign req_index = req_addr[LINE_OFFSET_WIDTH +: INDEX_WIDTH];
    assign req_tag = req_addr[cache_pkg::ADDR_WIDTH-1 -: TAG_WIDTH];
    assign req_word = req_addr[WORD_OFFSET_WIDTH +: WORD_SEL_WIDTH];
    assign req_offset = req_addr[WORD_OFFSET_WIDTH-1:0];

    assign cur_state = line_state[req_index];
    assign tag_match = line_tag[req_index] == req_tag;
    assign cur_dirty = |line_dirty[req_index];

    logic sb_push;
    logic sb_pop;
    logic sb_empty;
    logic sb_full;
    cache_pkg::addr_t sb_pop_addr;
    cache_pkg::word_t sb_pop_data;
    cache_pkg::word_t sb_fwd_data;
    logic [WB-1:0] sb_pop_mask;
    logic [WB-1:0] sb_fwd_mask;
    logic [NUM_LINES-1:0] sb_line_pending;

    // Drain one entry per cycle, except when a fill owns the arrays
    assign sb_pop = !sb_empty && !fill_valid;
    assign sb_push = req_write && cur_state != cache_pkg::INVALID && tag_match
                     && (!sb_full || sb_pop);

    store_buffer #(
        .SB_DEPTH(SB_DEPTH),
        .NUM_LINES(NUM_LINES)
    ) sb0 (
        .clock(clock),
        .reset(reset),
        .push(sb_push),
        .push_mode(req_mode),
        .push_addr(req_addr),
        .push_data(req_data),
        .pop(sb_pop),
        .lookup_addr(req_addr),
        .pop_addr(sb_pop_addr),
        .pop_data(sb_pop_data),
        .pop_mask(sb_pop_mask),
        .fwd_data(sb_fwd_data),
        .fwd_mask(sb_fwd_mask),
        .line_pending(sb_line_pending),
        .empty(sb_empty),
        .full(sb_full)
    );

    cache_pkg::word_t array_word;
    cache_pkg::word_t merged_word;
    logic [WB-1:0] array_mask;
    logic [WB-1:0] need_mask;
    logic read_hit;

    assign array_word = line_data[req_index][req_word*cache_pkg::WORD_WIDTH +: cache_pkg::WORD_WIDTH];

    // A requested line only holds the bytes stored since the fill started
    always_comb begin
        array_mask = '0;
        if (tag_match && cur_state == cache_pkg::VALID) begin
            array_mask = '1;
        end else if (tag_match && cur_state == cache_pkg::REQUESTED) begin
            array_mask = line_dirty[req_index][req_word*WB +: WB];
        end
    end

    for (genvar b = 0; b < WB; b++) begin : gen_merge
        assign merged_word[8*b +: 8] = sb_fwd_mask[b] ? sb_fwd_data[8*b +: 8]
                                                      : array_word[8*b +: 8];
    end

    assign need_mask = cache_pkg::mode_mask(req_mode, req_offset);
    assign read_hit = (need_mask & ~(array_mask | sb_fwd_mask)) == '0;

    always_comb begin
        case (req_mode)
            cache_pkg::BYTE:
                resp_data = cache_pkg::word_t'(merged_word[{req_offset, 3'b000} +: 8]);
            cache_pkg::HALF:
                resp_data = cache_pkg::word_t'(
                    merged_word[{req_offset[WORD_OFFSET_WIDTH-1:1], 4'b0000} +: 16]);
            default:
                resp_data = merged_word;
        endcase
    end

    assign resp_hit = (req_read && read_hit) || sb_push;

    logic miss_issue;
    logic line_quiet;

    assign miss_issue = req_read && !read_hit && !mem_busy;
    assign line_quiet = cur_state == cache_pkg::VALID && !sb_line_pending[req_index];

    // Dirty victim goes out first and the retry starts the fill
    assign mem_write = miss_issue && line_quiet && cur_dirty;
    assign mem_read = miss_issue
                      && (cur_state == cache_pkg::INVALID || (line_quiet && !cur_dirty));

    assign mem_line_addr = mem_write ? {line_tag[req_index], req_index}
                                     : req_addr[cache_pkg::ADDR_WIDTH-1:LINE_OFFSET_WIDTH];
    assign mem_wdata = line_data[req_index];

    logic [INDEX_WIDTH-1:0] fill_index;
    logic [INDEX_WIDTH-1:0] pop_index;
    logic [WORD_SEL_WIDTH-1:0] pop_word;

    assign fill_index = fill_line_addr[INDEX_WIDTH-1:0];
    assign pop_index = sb_pop_addr[LINE_OFFSET_WIDTH +: INDEX_WIDTH];
    assign pop_word = sb_pop_addr[WORD_OFFSET_WIDTH +: WORD_SEL_WIDTH];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < NUM_LINES; i++) begin
                line_state[i] <= cache_pkg::INVALID;
                line_dirty[i] <= '0;
            end
        end else begin
            if (mem_read) begin
                line_state[req_index] <= cache_pkg::REQUESTED;
                line_dirty[req_index] <= '0;
            end else if (mem_write) begin
                line_state[req_index] <= cache_pkg::INVALID;
            end
            // Bytes stored while the fill was out keep their dirty bits
            if (fill_valid) begin
                line_state[fill_index] <= cache_pkg::VALID;
            end
            if (sb_pop) begin
                for (int b = 0; b < WB; b++) begin
                    if (sb_pop_mask[b]) begin
                        line_dirty[pop_index][pop_word*WB + b] <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (mem_read) begin
            line_tag[req_index] <= req_tag;
        end
        if (fill_valid) begin
            for (int i = 0; i < cache_pkg::LINE_BYTES; i++) begin
                if (!line_dirty[fill_index][i]) begin
                    line_data[fill_index][8*i +: 8] <= fill_data[8*i +: 8];
                end
            end
        end
        if (sb_pop) begin
            for (int b = 0; b < WB; b++) begin
                if (sb_pop_mask[b]) begin
                    line_data[pop_index][pop_word*cache_pkg::WORD_WIDTH + 8*b +: 8]
                        <= sb_pop_data[8*b +: 8];
                end
            end
        end
    end

    fill_hits_requested: assert property (
        @(posedge clock) disable iff (reset)
        fill_valid |-> line_state[fill_index] == cache_pkg::REQUESTED
                       && line_tag[fill_index] == fill_line_addr[cache_pkg::LINE_ADDR_WIDTH-1 -: TAG_WIDTH]
    );

    mem_strobes_exclusive: assert property (
        @(posedge clock) disable iff (reset) !(mem_read && mem_write)
    );

endmodule

`default_nettype wire

//--- hdl/line_memory.sv
`default_nettype none

module line_memory #(
    parameter int MEM_LATENCY = 4
) (
    input wire clock,
    input wire reset,
    input wire mem_read,
    input wire mem_write,
    input wire [cache_pkg::LINE_ADDR_WIDTH-1:0] mem_line_addr,
    input wire cache_pkg::line_t mem_wdata,
    output logic mem_busy,
    output logic fill_valid,
    output logic [cache_pkg::LINE_ADDR_WIDTH-1:0] fill_line_addr,
    output cache_pkg::line_t fill_data
);

    localparam int NUM_MEM_LINES = 2 ** cache_pkg::LINE_ADDR_WIDTH;
    localparam int COUNT_WIDTH = $clog2(MEM_LATENCY + 1);

    cache_pkg::line_t mem_array [NUM_MEM_LINES];

    logic [COUNT_WIDTH-1:0] countdown;
    logic [cache_pkg::LINE_ADDR_WIDTH-1:0] read_addr;

    initial begin
        for (int i = 0; i < NUM_MEM_LINES; i++) begin
            mem_array[i] = '0;
        end
    end

    // Write-backs land at the strobe edge
    always @(posedge clock) begin
        if (mem_write) begin
            mem_array[mem_line_addr] <= mem_wdata;
        end
    end

    // Busy spans the whole read, fill cycle included
    always_ff @(posedge clock) begin
        if (reset) begin
            mem_busy <= 1'b0;
            countdown <= '0;
        end else if (mem_read) begin
            mem_busy <= 1'b1;
            countdown <= COUNT_WIDTH'(MEM_LATENCY - 1);
        end else if (fill_valid) begin
            mem_busy <= 1'b0;
        end else if (mem_busy) begin
            countdown <= countdown - 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (mem_read) begin
            read_addr <= mem_line_addr;
        end
    end

    assign fill_valid = mem_busy && countdown == '0;
    assign fill_line_addr = read_addr;
    assign fill_data = mem_array[read_addr];

    no_strobe_while_busy: assert property (
        @(posedge clock) disable iff (reset) mem_busy |-> !(mem_read || mem_write)
    );

endmodule

`default_nettype wire

//--- hdl/cache_subsystem.sv
`default_nettype none

module cache_subsystem #(
    parameter int NUM_LINES = 8,
    parameter int SB_DEPTH = 4,
    parameter int MEM_LATENCY = 4
) (
    input wire clock,
    input wire reset,
    input wire req_read,
    input wire req_write,
    input wire cache_pkg::access_mode_e req_mode,
    input wire cache_pkg::addr_t req_addr,
    input wire cache_pkg::word_t req_data,
    output logic resp_hit,
    output cache_pkg::word_t resp_data
);

    logic mem_read;
    logic mem_write;
    logic mem_busy;
    logic fill_valid;
    logic [cache_pkg::LINE_ADDR_WIDTH-1:0] mem_line_addr;
    logic [cache_pkg::LINE_ADDR_WIDTH-1:0] fill_line_addr;
    cache_pkg::line_t mem_wdata;
    cache_pkg::line_t fill_data;

    data_cache #(
        .NUM_LINES(NUM_LINES),
        .SB_DEPTH(SB_DEPTH)
    ) cache0 (
        .clock(clock),
        .reset(reset),
        .req_read(req_read),
        .req_write(req_write),
        .req_mode(req_mode),
        .req_addr(req_addr),
        .req_data(req_data),
        .mem_busy(mem_busy),
        .fill_valid(fill_valid),
        .fill_line_addr(fill_line_addr),
        .fill_data(fill_data),
        .resp_hit(resp_hit),
        .resp_data(resp_data),
        .mem_read(mem_read),
        .mem_write(mem_write),
        .mem_line_addr(mem_line_addr),
        .mem_wdata(mem_wdata)
    );

    line_memory #(
        .MEM_LATENCY(MEM_LATENCY)
    ) mem0 (
        .clock(clock),
        .reset(reset),
        .mem_read(mem_read),
        .mem_write(mem_write),
        .mem_line_addr(mem_line_addr),
        .mem_wdata(mem_wdata),
        .mem_busy(mem_busy),
        .fill_valid(fill_valid),
        .fill_line_addr(fill_line_addr),
        .fill_data(fill_data)
    );

endmodule

`default_nettype wire

//--- bench/tb_clock.sv
`default_nettype none

module tb_clock #(
    parameter int PERIOD = 20,
    parameter int RESET_CYCLES = 2
) (
    output logic clock,
    output logic reset
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2) clock = ~clock;
    end

    // Reset drops just after the last reset edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        #2;
        reset = 1'b0;
    end

endmodule

`default_nettype wire

//--- bench/cache_tb.sv
`default_nettype none

module cache_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_LINES = 8;
    localparam int SB_DEPTH = 4;
    localparam int MEM_LATENCY = 4;
    localparam int CLOCK_PERIOD = 20;
    localparam int DRIVE_DELAY = 2;
    localparam int NUM_TESTS = 5;
    localparam int RETRY_LIMIT = 20;

    logic clock;
    logic reset;
    logic req_read;
    logic req_write;
    cache_pkg::access_mode_e req_mode;
    cache_pkg::addr_t req_addr;
    cache_pkg::word_t req_data;
    logic resp_hit;
    cache_pkg::word_t resp_data;

    // Byte image of what memory plus cache should hold
    logic [7:0] shadow [2 ** cache_pkg::ADDR_WIDTH];
    logic [31:0] lcg_state;
    string test_name;
    int test_errors;
    int total_errors;
    int check_count;
    int tests_run;
    int tests_failed;

    tb_clock #(
        .PERIOD(CLOCK_PERIOD),
        .RESET_CYCLES(2)
    ) clock0 (
        .clock(clock),
        .reset(reset)
    );

    cache_subsystem #(
        .NUM_LINES(NUM_LINES),
        .SB_DEPTH(SB_DEPTH),
        .MEM_LATENCY(MEM_LATENCY)
    ) dut0 (
        .clock(clock),
        .reset(reset),
        .req_read(req_read),
        .req_write(req_write),
        .req_mode(req_mode),
        .req_addr(req_addr),
        .req_data(req_data),
        .resp_hit(resp_hit),
        .resp_data(resp_data)
    );

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        // Low bits of an LCG repeat quickly, so swap halves
        return {lcg_state[15:0], lcg_state[31:16]};
    endfunction

    function automatic int access_size(cache_pkg::access_mode_e mode);
        case (mode)
            cache_pkg::BYTE: return 1;
            cache_pkg::HALF: return 2;
            default: return 4;
        endcase
    endfunction

    // Naturally aligned bytes, zero-extended into the low end
    function automatic cache_pkg::word_t expected_load(
        cache_pkg::access_mode_e mode,
        cache_pkg::addr_t addr
    );
        cache_pkg::word_t value;
        cache_pkg::addr_t base;
        int size;
        size = access_size(mode);
        base = addr - cache_pkg::addr_t'(addr % size);
        value = '0;
        for (int i = 0; i < size; i++) begin
            value[8*i +: 8] = shadow[base + i];
        end
        return value;
    endfunction

    task automatic shadow_store(
        input cache_pkg::access_mode_e mode,
        input cache_pkg::addr_t addr,
        input cache_pkg::word_t data
    );
        cache_pkg::addr_t base;
        int size;
        size = access_size(mode);
        base = addr - cache_pkg::addr_t'(addr % size);
        for (int i = 0; i < size; i++) begin
            shadow[base + i] = data[8*i +: 8];
        end
    endtask

    task automatic compare_word(input cache_pkg::word_t expected, input cache_pkg::word_t actual);
        check_count++;
        if (expected !== actual) begin
            test_errors++;
            $display("error %s: expected %h actual %h", test_name, expected, actual);
        end
    endtask

    task automatic compare_bit(input logic expected, input logic actual);
        check_count++;
        if (expected !== actual) begin
            test_errors++;
            $display("error %s: expected %b actual %b", test_name, expected, actual);
        end
    endtask

    task automatic report_failure(input string what);
        test_errors++;
        $display("%s: %s", test_name, what);
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests_run++;
        total_errors += test_errors;
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("%s: %s, %0d errors", test_name, (test_errors == 0) ? "pass" : "fail",
                 test_errors);
    endtask

    // One request cycle, sampled mid-cycle; a hit store is taken at the edge
    task automatic request_once(
        input logic is_write,
        input cache_pkg::access_mode_e mode,
        input cache_pkg::addr_t addr,
        input cache_pkg::word_t data,
        output logic hit,
        output cache_pkg::word_t rdata
    );
        req_read = !is_write;
        req_write = is_write;
        req_mode = mode;
        req_addr = addr;
        req_data = data;
        @(negedge clock);
        hit = resp_hit;
        rdata = resp_data;
        @(posedge clock);
        if (is_write && hit) begin
            shadow_store(mode, addr, data);
        end
        #(DRIVE_DELAY);
        req_read = 1'b0;
        req_write = 1'b0;
    endtask

    task automatic request_until_hit(
        input logic is_write,
        input cache_pkg::access_mode_e mode,
        input cache_pkg::addr_t addr,
        input cache_pkg::word_t data,
        output cache_pkg::word_t rdata,
        output int retries,
        output logic ok
    );
        logic hit;
        retries = 0;
        request_once(is_write, mode, addr, data, hit, rdata);
        while (!hit && retries < RETRY_LIMIT) begin
            retries++;
            request_once(is_write, mode, addr, data, hit, rdata);
        end
        ok = hit;
        if (!hit) begin
            report_failure($sformatf("%s at address %h still missed after %0d retries",
                                     is_write ? "store" : "load", addr, RETRY_LIMIT));
        end
    endtask

    task automatic load_and_check(
        input cache_pkg::access_mode_e mode,
        input cache_pkg::addr_t addr
    );
        cache_pkg::word_t rdata;
        int retries;
        logic ok;
        request_until_hit(1'b0, mode, addr, '0, rdata, retries, ok);
        if (ok) begin
            compare_word(expected_load(mode, addr), rdata);
        end
    endtask

    task automatic store_value(
        input cache_pkg::access_mode_e mode,
        input cache_pkg::addr_t addr,
        input cache_pkg::word_t data
    );
        cache_pkg::word_t rdata;
        int retries;
        logic ok;
        request_until_hit(1'b1, mode, addr, data, rdata, retries, ok);
    endtask

    task automatic cold_load();
        cache_pkg::word_t rdata;
        int retries;
        logic hit;
        logic ok;
        begin_test("cold_load");
        request_once(1'b1, cache_pkg::WORD, 16'h0100, 32'hdeadbeef, hit, rdata);
        compare_bit(1'b0, hit);
        // First load attempt starts the fill
        request_once(1'b0, cache_pkg::WORD, 16'h0100, '0, hit, rdata);
        compare_bit(1'b0, hit);
        request_until_hit(1'b0, cache_pkg::WORD, 16'h0100, '0, rdata, retries, ok);
        if (ok) begin
            compare_word(expected_load(cache_pkg::WORD, 16'h0100), rdata);
            if (retries + 1 > MEM_LATENCY + 1) begin
                report_failure($sformatf("cold load needed %0d cycles, limit is %0d",
                                         retries + 1, MEM_LATENCY + 1));
            end
        end
        end_test();
    endtask

    task automatic store_forwarding();
        cache_pkg::access_mode_e store_modes [5] = '{cache_pkg::BYTE, cache_pkg::HALF,
            cache_pkg::WORD, cache_pkg::BYTE, cache_pkg::HALF};
        int offsets [5] = '{1, 6, 8, 15, 2};
        cache_pkg::addr_t addr;
        begin_test("store_forwarding");
        load_and_check(cache_pkg::WORD, 16'h0240);
        for (int s = 0; s < 5; s++) begin
            addr = 16'h0240 + cache_pkg::addr_t'(offsets[s]);
            store_value(store_modes[s], addr, next_random());
            // First read lands while the store is still buffered
            for (int m = 0; m < 3; m++) begin
                load_and_check(cache_pkg::access_mode_e'(m), addr);
            end
        end
        end_test();
    endtask

    task automatic store_miss();
        cache_pkg::addr_t targets [3] = '{16'h0330, 16'h0640, 16'h0900};
        cache_pkg::word_t rdata;
        logic hit;
        begin_test("store_miss");
        // Invalid index 3, then tag mismatches on indexes 4 and 0
        for (int t = 0; t < 3; t++) begin
            repeat (3) begin
                request_once(1'b1, cache_pkg::WORD, targets[t], next_random(), hit, rdata);
                compare_bit(1'b0, hit);
            end
        end
        load_and_check(cache_pkg::WORD, 16'h0248);
        load_and_check(cache_pkg::WORD, 16'h0100);
        end_test();
    endtask

    task automatic fill_merge();
        cache_pkg::word_t rdata;
        logic hit;
        begin_test("fill_merge");
        // Put nonzero data for line 0x0a50 into memory by eviction
        load_and_check(cache_pkg::WORD, 16'h0a50);
        store_value(cache_pkg::WORD, 16'h0a54, next_random());
        store_value(cache_pkg::WORD, 16'h0a58, next_random());
        load_and_check(cache_pkg::WORD, 16'h0ad0);
        request_once(1'b0, cache_pkg::WORD, 16'h0a54, '0, hit, rdata);
        compare_bit(1'b0, hit);
        request_once(1'b1, cache_pkg::HALF, 16'h0a56, next_random(), hit, rdata);
        compare_bit(1'b1, hit);
        load_and_check(cache_pkg::WORD, 16'h0a54);
        for (int w = 0; w < 4; w++) begin
            load_and_check(cache_pkg::WORD, 16'h0a50 + cache_pkg::addr_t'(4 * w));
        end
        end_test();
    endtask

    task automatic conflict_eviction();
        logic [31:0] r;
        cache_pkg::addr_t first;
        cache_pkg::addr_t second;
        cache_pkg::access_mode_e mode;
        begin_test("conflict_eviction");
        for (int round = 0; round < 4; round++) begin
            r = next_random();
            first = cache_pkg::addr_t'(r);
            mode = cache_pkg::access_mode_e'(r[31:16] % 3);
            // Same index, some other tag
            second = first ^ cache_pkg::addr_t'(((next_random() % 511) + 1) << 7);
            load_and_check(cache_pkg::WORD, first);
            store_value(mode, first, next_random());
            load_and_check(cache_pkg::WORD, second);
            load_and_check(mode, first);
            load_and_check(cache_pkg::WORD, first);
        end
        end_test();
    endtask

    initial begin
        #(NUM_TESTS * 200 * CLOCK_PERIOD);
        $display("watchdog expired at %0t, the tests did not finish", $time);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        req_read = 1'b0;
        req_write = 1'b0;
        req_mode = cache_pkg::WORD;
        req_addr = '0;
        req_data = '0;
        lcg_state = 32'd29;
        total_errors = 0;
        check_count = 0;
        tests_run = 0;
        tests_failed = 0;
        for (int i = 0; i < 2 ** cache_pkg::ADDR_WIDTH; i++) begin
            shadow[i] = 8'h00;
        end
        @(negedge reset);
        @(posedge clock);
        #(DRIVE_DELAY);
        cold_load();
        store_forwarding();
        store_miss();
        fill_merge();
        conflict_eviction();
        $display("summary: %0d tests run, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, check_count, total_errors);
        if (tests_failed == 0 && total_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- cache_subsystem.f
hdl/cache_pkg.sv
hdl/store_buffer.sv
hdl/data_cache.sv
hdl/line_memory.sv
hdl/cache_subsystem.sv
bench/tb_clock.sv
bench/cache_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert --timescale 1ns/100ps -Wno-fatal -j 0
TOP = cache_tb
FILELIST = cache_subsystem.f
BUILD_DIR = obj_dir
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^TESTS PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
